// ==== build.f ====
+incdir+dv
hdl/klxLoadPkg.sv
hdl/klxCharDecode.sv
hdl/klxRecordExecute.sv
hdl/klxRamWriteResult.sv
hdl/klxLoader.sv
dv/tbClock.sv
dv/klxLoaderTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the loader testbench with Verilator, runs it into sim.log and
# decides pass or fail from the log alone
rm -rf obj_dir sim.log &&
verilator --binary --timing -Wno-fatal -f build.f --top-module klxLoaderTb \
  -o klxLoaderSim &&
{ ./obj_dir/klxLoaderSim > sim.log 2>&1 || true; } &&
grep -q "SIMULATION PASSED" sim.log &&
echo "run.sh: pass, see sim.log" ||
{ echo "run.sh: fail, see sim.log"; exit 1; }

// ==== dv/klxLoaderChecks.svh ====
// Must be included inside the testbench module after abortRun is declared
`ifndef klxLoaderChecksSvh
`define klxLoaderChecksSvh

// CRAM beat with the address first and then the 86-bit word
task automatic compareCram(klxLoadPkg::cramWriteT actual, klxLoadPkg::cramWriteT expected);
  if (actual.addr !== expected.addr) begin
    abortRun($sformatf("ERROR cramWrite.addr got %h expected %h", actual.addr, expected.addr));
  end else if (actual.word !== expected.word) begin
    abortRun($sformatf("ERROR cramWrite.word got %h expected %h", actual.word, expected.word));
  end
endtask

// DRAM pair beat
task automatic compareDram(klxLoadPkg::dramWriteT actual, klxLoadPkg::dramWriteT expected);
  if (actual.addr !== expected.addr) begin
    abortRun($sformatf("ERROR dramWrite.addr got %h expected %h", actual.addr, expected.addr));
  end else if (actual.even !== expected.even) begin
    abortRun($sformatf("ERROR dramWrite.even got %h expected %h", actual.even, expected.even));
  end else if (actual.odd !== expected.odd) begin
    abortRun($sformatf("ERROR dramWrite.odd got %h expected %h", actual.odd, expected.odd));
  end
endtask

// End-of-line report
task automatic compareStatus(klxLoadPkg::lineStatusT actual,
                             klxLoadPkg::lineStatusT expected);
  if (actual.ok !== expected.ok) begin
    abortRun($sformatf("ERROR lineStatus.ok got %h expected %h", actual.ok, expected.ok));
  end
endtask

`endif

// ==== dv/klxLoaderTb.sv ====
// Lines are fixed-seed random and inputs change on falling edges only
`timescale 1ns/1ps

module klxLoaderTb;

  typedef enum logic [1:0] {evCram, evDram, evStatus} eventKindT;

  // One expected output in arrival order
  typedef struct packed {
    eventKindT kind;
    klxLoadPkg::cramWriteT cram;
    klxLoadPkg::dramWriteT dram;
    klxLoadPkg::lineStatusT status;
  } expEventT;

  logic clk;
  logic rstN;
  logic [klxLoadPkg::charWidth-1:0] charIn;
  logic charValid;
  logic creditReturn;
  klxLoadPkg::cramWriteT cramWrite;
  klxLoadPkg::dramWriteT dramWrite;
  klxLoadPkg::lineStatusT lineStatus;

  logic [31:0] rngState;
  logic [klxLoadPkg::charWidth-1:0] charQ [$];
  logic [klxLoadPkg::fieldWidth-1:0] dataQ [$];
  expEventT expQ [$];
  // Model copy of the continuation address
  logic [klxLoadPkg::cramAddrWidth-1:0] rememberedAddr;
  // Set while a line's beats run since its status must follow without a gap
  bit beatRun;
  int credits;
  int sentCount;
  int returnedCount;

  tbClock clockGen (
    .clk(clk),
    .rstN(rstN)
  );

  klxLoader UUT (
    .clk(clk),
    .rstN(rstN),
    .charIn(charIn),
    .charValid(charValid),
    .creditReturn(creditReturn),
    .cramWrite(cramWrite),
    .dramWrite(dramWrite),
    .lineStatus(lineStatus)
  );

  task automatic abortRun(string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  `include "klxLoaderChecks.svh"

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // xorshift32
  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // Six bits per character with octal 100 set and leading zero characters left out
  task automatic appendField(logic [15:0] value);
    if (value[15:12] != '0) begin
      charQ.push_back({3'b100, value[15:12]});
    end
    if (value[15:6] != '0) begin
      charQ.push_back({1'b1, value[11:6]});
    end
    charQ.push_back({1'b1, value[5:0]});
  endtask

  // Type, space, WC, ADR, data words, CKSUM, newline
  task automatic encodeLine(logic [6:0] typeChar, logic [15:0] wc, logic [15:0] adr,
                            logic [15:0] cksum);
    charQ.push_back(typeChar);
    charQ.push_back(klxLoadPkg::charSpace);
    appendField(wc);
    charQ.push_back(klxLoadPkg::charComma);
    appendField(adr);
    charQ.push_back(klxLoadPkg::charComma);
    foreach (dataQ[i]) begin
      appendField(dataQ[i]);
      charQ.push_back(klxLoadPkg::charComma);
    end
    appendField(cksum);
    charQ.push_back(klxLoadPkg::charNewline);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // J0 zero, J1..J4 common[3:0], J5 J6 zero, J7 odd[3], J8..J10 own[2:0]
  function automatic klxLoadPkg::dramEntryT makeEntry(logic [15:0] own, logic [15:0] odd,
                                                      logic [15:0] common);
    klxLoadPkg::dramEntryT e;
    e = '0;
    e.aField = own[13:11];
    e.bField = own[10:8];
    e.parity = own[5];
    e.jField[1:4] = common[3:0];
    e.jField[7] = odd[3];
    e.jField[8:10] = own[2:0];
    return e;
  endfunction

  // Bit 0 is the MSB and words one to five fill 64-79 down to 0-15
  function automatic logic [0:klxLoadPkg::cramWordWidth-1] cramImage(int first);
    logic [0:klxLoadPkg::cramWordWidth-1] w;
    logic [15:0] sixth;
    w[64:79] = dataQ[first];
    w[48:63] = dataQ[first+1];
    w[32:47] = dataQ[first+2];
    w[16:31] = dataQ[first+3];
    w[0:15] = dataQ[first+4];
    sixth = dataQ[first+5];
    w[80:85] = sixth[5:0];
    return w;
  endfunction

  // Queues the beats and status of one line held in dataQ
  task automatic predictLine(logic [6:0] typeChar, logic [15:0] wc, logic [15:0] adr,
                             logic [15:0] cksum);
    logic [15:0] sum;
    logic [10:0] base;
    logic [10:0] addr;
    bit isC;
    bit isD;
    bit good;
    int step;
    int beats;
    expEventT ev;
    isC = typeChar == klxLoadPkg::charTypeC;
    isD = typeChar == klxLoadPkg::charTypeD;
    step = isD ? klxLoadPkg::dramWordsPerPair : klxLoadPkg::cramWordsPerLoc;
    sum = wc + adr + cksum;
    foreach (dataQ[i]) begin
      sum = sum + dataQ[i];
    end
    good = (isC || isD) && (dataQ.size() == int'(wc)) && (sum == '0) &&
           (int'(wc) <= klxLoadPkg::maxDataWords) && (int'(wc) % step == 0);
    base = (adr == '0) ? rememberedAddr : adr[10:0];
    beats = good ? int'(wc) / step : 0;
    for (int b = 0; b < beats; b++) begin
      ev = '0;
      if (isD) begin
        // Words come as even, odd and common and pairs step by two
        addr = base + 11'(2 * b);
        ev.kind = evDram;
        ev.dram.valid = 1'b1;
        ev.dram.addr = addr[8:0];
        ev.dram.even = makeEntry(dataQ[3*b], dataQ[3*b+1], dataQ[3*b+2]);
        ev.dram.odd = makeEntry(dataQ[3*b+1], dataQ[3*b+1], dataQ[3*b+2]);
      end else begin
        ev.kind = evCram;
        ev.cram.valid = 1'b1;
        ev.cram.addr = base + 11'(b);
        ev.cram.word = cramImage(6 * b);
      end
      expQ.push_back(ev);
    end
    // End of block clears and any other good line continues after its last write
    if (good) begin
      rememberedAddr = (wc == '0 && adr == '0) ? '0 : base + 11'(isD ? 2 * beats : beats);
    end
    ev = '0;
    ev.kind = evStatus;
    ev.status.done = 1'b1;
    ev.status.ok = good;
    expQ.push_back(ev);
  endtask

  // Cycle of nine with 0 end of block, 1 3 6 continuation, 2 C, 4 D,
  // 5 bad checksum, 7 bad WC, 8 unknown type
  task automatic makeLine(int kind);
    logic [6:0] typeChar;
    logic [15:0] wc;
    logic [15:0] adr;
    logic [15:0] sum;
    logic [15:0] cksum;
    bit useD;
    int n;
    useD = nextRandom() % 2 == 1;
    if (kind == 2) begin
      useD = 1'b0;
    end else if (kind == 4) begin
      useD = 1'b1;
    end
    typeChar = useD ? klxLoadPkg::charTypeD : klxLoadPkg::charTypeC;
    n = useD ? 3 * int'(1 + nextRandom() % 10) : 6 * int'(1 + nextRandom() % 5);
    adr = 16'(1 + nextRandom() % 2047);
    if (kind == 0) begin
      n = 0;
      adr = '0;
    end else if (kind == 1 || kind == 3 || kind == 6) begin
      adr = '0;
    end
    dataQ.delete();
    for (int i = 0; i < n; i++) begin
      dataQ.push_back(16'(nextRandom()));
    end
    wc = 16'(n);
    // Checksum still matches the wrong count
    if (kind == 7) begin
      wc = (n <= 24) ? wc + 16'd6 : wc - 16'd6;
    end
    sum = wc + adr;
    foreach (dataQ[i]) begin
      sum = sum + dataQ[i];
    end
    cksum = -sum;
    if (kind == 5) begin
      cksum = cksum + 16'(1 + nextRandom() % 65535);
    end
    // Z records are not supported
    if (kind == 8) begin
      typeChar = 7'h5a;
    end
    predictLine(typeChar, wc, adr, cksum);
    encodeLine(typeChar, wc, adr, cksum);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor called once per falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic checkOutputs(output bit sawEvent);
    expEventT ev;
    int fired;
    fired = int'(cramWrite.valid) + int'(dramWrite.valid) + int'(lineStatus.done);
    sawEvent = fired != 0;
    if (fired > 1) begin
      abortRun("more than one output fired in the same cycle");
    end else if (fired == 1) begin
      if (expQ.size() == 0) begin
        abortRun("an output fired with no line pending");
      end else begin
        ev = expQ.pop_front();
        case (ev.kind)
          evCram: begin
            if (!cramWrite.valid) begin
              abortRun("expected a CRAM write but another output fired");
            end else begin
              compareCram(cramWrite, ev.cram);
            end
          end
          evDram: begin
            if (!dramWrite.valid) begin
              abortRun("expected a DRAM write but another output fired");
            end else begin
              compareDram(dramWrite, ev.dram);
            end
          end
          default: begin
            if (!lineStatus.done) begin
              abortRun("expected a line status but a write fired");
            end else begin
              compareStatus(lineStatus, ev.status);
            end
          end
        endcase
        beatRun = ev.kind != evStatus;
      end
    end else if (beatRun) begin
      abortRun("gap after a write beat before the line finished");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int waitCycles;
    int idleCycles;
    bit sawEvent;
    bit progress;
    charIn = '0;
    charValid = 1'b0;
    rngState = 32'h5bb0;
    rememberedAddr = '0;
    beatRun = 1'b0;
    sentCount = 0;
    returnedCount = 0;
    credits = klxLoadPkg::creditDepth;

    // All outputs quiet while reset is held
    waitCycles = 0;
    do begin
      @(negedge clk);
      if (creditReturn || cramWrite.valid || dramWrite.valid || lineStatus.done) begin
        abortRun("an output was active during reset");
      end
      waitCycles++;
      if (waitCycles > 100) begin
        abortRun("timeout waiting for reset release");
      end
    end while (!rstN);

    for (int i = 0; i < 36; i++) begin
      makeLine(i % 9);
    end

    // Send against credits where a returned credit is usable from the next cycle
    idleCycles = 0;
    while (charQ.size() > 0 || expQ.size() > 0 || sentCount != returnedCount) begin
      @(negedge clk);
      checkOutputs(sawEvent);
      progress = sawEvent || creditReturn;
      if (creditReturn) begin
        returnedCount++;
      end
      if (returnedCount > sentCount) begin
        abortRun("a credit came back for a character that was never sent");
      end
      // Decode pops nothing while a line replays
      if (creditReturn && (cramWrite.valid || dramWrite.valid)) begin
        abortRun("a credit came back while a line was replaying");
      end
      if (credits > 0 && charQ.size() > 0) begin
        charIn = charQ.pop_front();
        charValid = 1'b1;
        credits--;
        sentCount++;
        progress = 1'b1;
      end else begin
        charIn = '0;
        charValid = 1'b0;
      end
      if (creditReturn) begin
        credits++;
      end
      idleCycles = progress ? 0 : idleCycles + 1;
      if (idleCycles > 200) begin
        abortRun("timeout, the loader made no progress for 200 cycles");
      end
    end

    // Nothing more may come out once every line is reported
    repeat (20) begin
      @(negedge clk);
      checkOutputs(sawEvent);
      if (creditReturn) begin
        abortRun("a credit came back after all characters were returned");
      end
    end

    $display("sent %0d characters, %0d credits returned", sentCount, returnedCount);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== dv/tbClock.sv ====
// 20 ns clock from time 0, rstN low for 16 cycles and released 5 ns after a rising edge
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Release lands mid high phase, away from both edges
  initial begin
    rstN = 1'b0;
    repeat (16) @(posedge clk);
    #5 rstN = 1'b1;
  end

endmodule

// ==== hdl/klxLoader.sv ====
// Source starts with creditDepth credits and sends a character only while it holds one
`timescale 1ns/1ps

module klxLoader (
  input  logic clk,
  input  logic rstN,
  input  logic [klxLoadPkg::charWidth-1:0] charIn,
  input  logic charValid,
  output logic creditReturn,
  output klxLoadPkg::cramWriteT cramWrite,
  output klxLoadPkg::dramWriteT dramWrite,
  output klxLoadPkg::lineStatusT lineStatus
);

  // Decode to execute
  klxLoadPkg::fieldTokenT token;
  logic hold;

  // Execute to result
  klxLoadPkg::lineJobT job;
  klxLoadPkg::loadWordT [klxLoadPkg::cramWordsPerLoc-1:0] bufWord;
  logic lineBad;
  logic [klxLoadPkg::bufIndexWidth-1:0] bufIndex;
  logic jobDone;

  klxCharDecode decode (
    .clk(clk),
    .rstN(rstN),
    .charIn(charIn),
    .charValid(charValid),
    .hold(hold),
    .creditReturn(creditReturn),
    .token(token)
  );

  klxRecordExecute execute (
    .clk(clk),
    .rstN(rstN),
    .token(token),
    .jobDone(jobDone),
    .bufIndex(bufIndex),
    .hold(hold),
    .job(job),
    .bufWord(bufWord),
    .lineBad(lineBad)
  );

  klxRamWriteResult result (
    .clk(clk),
    .rstN(rstN),
    .job(job),
    .bufWord(bufWord),
    .lineBad(lineBad),
    .bufIndex(bufIndex),
    .jobDone(jobDone),
    .cramWrite(cramWrite),
    .dramWrite(dramWrite),
    .lineStatus(lineStatus)
  );

endmodule

// ==== hdl/klxRamWriteResult.sv ====
// Write ports have no back-pressure and get one beat per clock, job counts are whole beats
`timescale 1ns/1ps

module klxRamWriteResult (
  input  logic clk,
  input  logic rstN,
  input  klxLoadPkg::lineJobT job,
  input  klxLoadPkg::loadWordT [klxLoadPkg::cramWordsPerLoc-1:0] bufWord,
  input  logic lineBad,
  output logic [klxLoadPkg::bufIndexWidth-1:0] bufIndex,
  output logic jobDone,
  output klxLoadPkg::cramWriteT cramWrite,
  output klxLoadPkg::dramWriteT dramWrite,
  output klxLoadPkg::lineStatusT lineStatus
);

  logic active;
  logic isDram;
  logic badLatched;
  logic lastBeat;
  logic [klxLoadPkg::cramAddrWidth-1:0] beatAddr;
  logic [klxLoadPkg::wordCountWidth-1:0] remaining;
  logic [klxLoadPkg::wordCountWidth-1:0] step;
  logic [3:0] commonJ;

  // J1..J4 from common, J5 and J6 absent, J7 shared from the odd word
  function automatic klxLoadPkg::dramEntryT buildEntry(klxLoadPkg::dramDataWordT own,
                                                      klxLoadPkg::dramDataWordT odd,
                                                      logic [3:0] common);
    buildEntry.aField = own.aField;
    buildEntry.bField = own.bField;
    buildEntry.parity = own.parity;
    buildEntry.jField = {1'b0, common, 2'b00, odd.jLow[3], own.jLow[2:0]};
  endfunction

  assign step = isDram ? klxLoadPkg::dramStep : klxLoadPkg::cramStep;
  assign lastBeat = active && (remaining == step);
  assign commonJ = bufWord[2].raw[3:0];

  // Words land on bits 64-79, 48-63, 32-47, 16-31, 0-15, then 80-85
  assign cramWrite.valid = active && !isDram;
  assign cramWrite.addr = beatAddr;
  assign cramWrite.word = {bufWord[4].raw, bufWord[3].raw, bufWord[2].raw,
                           bufWord[1].raw, bufWord[0].raw, bufWord[5].raw[5:0]};

  // Even, odd, common
  assign dramWrite.valid = active && isDram;
  assign dramWrite.addr = beatAddr[klxLoadPkg::dramAddrWidth-1:0];
  assign dramWrite.even = buildEntry(bufWord[0].dram, bufWord[1].dram, commonJ);
  assign dramWrite.odd = buildEntry(bufWord[1].dram, bufWord[1].dram, commonJ);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      active <= 1'b0;
      isDram <= 1'b0;
      badLatched <= 1'b0;
      beatAddr <= '0;
      remaining <= '0;
      bufIndex <= '0;
      jobDone <= 1'b0;
      lineStatus <= '0;
    end else begin
      jobDone <= 1'b0;
      lineStatus <= '0;
      if (job.valid) begin
        isDram <= job.isDram;
        beatAddr <= job.baseAddr;
        remaining <= job.wordCount;
        bufIndex <= '0;
        badLatched <= lineBad;
        active <= job.wordCount != '0;
        // Nothing to write so report straight away
        if (job.wordCount == '0) begin
          jobDone <= 1'b1;
          lineStatus <= '{done: 1'b1, ok: !lineBad};
        end
      end else if (active) begin
        bufIndex <= bufIndex + step;
        beatAddr <= beatAddr + klxLoadPkg::cramAddrWidth'(isDram ? 2 : 1);
        remaining <= remaining - step;
        if (lastBeat) begin
          active <= 1'b0;
          jobDone <= 1'b1;
          lineStatus <= '{done: 1'b1, ok: !badLatched};
        end
      end
    end
  end

endmodule

// ==== hdl/klxRecordExecute.sv ====
// Only one line may be in flight, the buffer is not written again until result releases hold
`timescale 1ns/1ps

module klxRecordExecute (
  input  logic clk,
  input  logic rstN,
  input  klxLoadPkg::fieldTokenT token,
  input  logic jobDone,
  input  logic [klxLoadPkg::bufIndexWidth-1:0] bufIndex,
  output logic hold,
  output klxLoadPkg::lineJobT job,
  output klxLoadPkg::loadWordT [klxLoadPkg::cramWordsPerLoc-1:0] bufWord,
  output logic lineBad
);

  klxLoadPkg::loadWordT lineBuf [klxLoadPkg::maxDataWords];
  logic [klxLoadPkg::fieldCountWidth-1:0] fieldCount;
  logic [klxLoadPkg::fieldCountWidth-1:0] dataIdx;
  logic [klxLoadPkg::fieldCountWidth-1:0] expectedCount;
  logic [klxLoadPkg::fieldWidth-1:0] lineSum;
  logic [klxLoadPkg::fieldWidth-1:0] wcField;
  logic [klxLoadPkg::fieldWidth-1:0] adrField;
  logic [klxLoadPkg::cramAddrWidth-1:0] rememberedAddr;
  logic [klxLoadPkg::cramAddrWidth-1:0] baseAddr;
  logic [klxLoadPkg::cramAddrWidth-1:0] nextAddr;
  logic [klxLoadPkg::wordCountWidth-1:0] wordCount;
  logic [klxLoadPkg::wordCountWidth-1:0] locCount;
  logic [klxLoadPkg::wordCountWidth-1:0] pairCount;
  logic busy;
  logic fieldTok;
  logic endTok;
  logic isCram;
  logic isDram;
  logic wcFits;
  logic stepOk;
  logic lineGood;
  logic endOfBlock;

  assign fieldTok = token.valid && (token.kind == klxLoadPkg::tokField);
  assign endTok = token.valid && (token.kind == klxLoadPkg::tokLineEnd);
  // Covers the line-end cycle too, before busy is set
  assign hold = busy || endTok;

  // Fields from the third on go to the buffer, CKSUM lands there as well
  assign dataIdx = fieldCount - klxLoadPkg::fieldCountWidth'(2);

  //////////////////////////////////////////////////////////////////////
  // Line checks, evaluated on the line-end token
  //////////////////////////////////////////////////////////////////////

  assign wordCount = wcField[klxLoadPkg::wordCountWidth-1:0];
  // WC, ADR and CKSUM around the data
  assign expectedCount = klxLoadPkg::fieldCountWidth'(wordCount) +
                         klxLoadPkg::fieldCountWidth'(3);
  assign isCram = token.typeChar == klxLoadPkg::charTypeC;
  assign isDram = token.typeChar == klxLoadPkg::charTypeD;
  assign wcFits = wcField <= klxLoadPkg::maxWordCount;
  assign locCount = wordCount / klxLoadPkg::cramStep;
  assign pairCount = wordCount / klxLoadPkg::dramStep;
  assign stepOk = isDram ? ((wordCount % klxLoadPkg::dramStep) == '0)
                         : ((wordCount % klxLoadPkg::cramStep) == '0);
  // Running sum includes the negated checksum so a good line sums to zero
  assign lineGood = (isCram || isDram) && wcFits && stepOk &&
                    (fieldCount == expectedCount) && (lineSum == '0);
  assign endOfBlock = (wcField == '0) && (adrField == '0);

  // ADR of zero continues after the previous line
  assign baseAddr = (adrField == '0) ? rememberedAddr
                                     : adrField[klxLoadPkg::cramAddrWidth-1:0];
  // DRAM pairs step the address by two
  assign nextAddr = isDram ? baseAddr + klxLoadPkg::cramAddrWidth'({pairCount, 1'b0})
                           : baseAddr + klxLoadPkg::cramAddrWidth'(locCount);

  //////////////////////////////////////////////////////////////////////
  // Field state and job issue
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      fieldCount <= '0;
      lineSum <= '0;
      wcField <= '0;
      adrField <= '0;
      rememberedAddr <= '0;
      busy <= 1'b0;
      job <= '0;
      lineBad <= 1'b0;
    end else begin
      job.valid <= 1'b0;
      if (token.valid && token.kind == klxLoadPkg::tokType) begin
        fieldCount <= '0;
        lineSum <= '0;
      end else if (fieldTok) begin
        lineSum <= lineSum + token.value;
        if (fieldCount != '1) begin
          fieldCount <= fieldCount + 1'b1;
        end
        if (fieldCount == '0) begin
          wcField <= token.value;
        end
        if (fieldCount == klxLoadPkg::fieldCountWidth'(1)) begin
          adrField <= token.value;
        end
      end else if (endTok) begin
        busy <= 1'b1;
        // Bad and end-of-block lines go out as zero-count jobs
        job <= '{valid: 1'b1, isDram: isDram, baseAddr: baseAddr,
                 wordCount: lineGood ? wordCount : '0};
        lineBad <= !lineGood;
        if (lineGood) begin
          rememberedAddr <= endOfBlock ? '0 : nextAddr;
        end
      end
      if (jobDone) begin
        busy <= 1'b0;
      end
    end
  end

  // Data words, CKSUM of a full line falls past the end and is dropped
  always_ff @(posedge clk) begin
    if (fieldTok && (fieldCount >= klxLoadPkg::fieldCountWidth'(2)) &&
        (dataIdx < klxLoadPkg::fieldCountWidth'(klxLoadPkg::maxDataWords))) begin
      lineBuf[dataIdx[klxLoadPkg::bufIndexWidth-1:0]].raw <= token.value;
    end
  end

  // Window of one beat's words starting at bufIndex
  always_comb begin
    logic [klxLoadPkg::bufIndexWidth:0] readIdx;
    for (int k = 0; k < klxLoadPkg::cramWordsPerLoc; k++) begin
      readIdx = {1'b0, bufIndex} + (klxLoadPkg::bufIndexWidth + 1)'(k);
      if (readIdx < (klxLoadPkg::bufIndexWidth + 1)'(klxLoadPkg::maxDataWords)) begin
        bufWord[k] = lineBuf[readIdx[klxLoadPkg::bufIndexWidth-1:0]];
      end else begin
        bufWord[k] = '0;
      end
    end
  end

endmodule

// ==== hdl/klxCharDecode.sv ====
// charValid may only be raised against a held credit, and the first character of a line is its type
`timescale 1ns/1ps

module klxCharDecode (
  input  logic clk,
  input  logic rstN,
  input  logic [klxLoadPkg::charWidth-1:0] charIn,
  input  logic charValid,
  input  logic hold,
  output logic creditReturn,
  output klxLoadPkg::fieldTokenT token
);

  logic [klxLoadPkg::charWidth-1:0] fifoMem [klxLoadPkg::creditDepth];
  logic [klxLoadPkg::creditPtrWidth-1:0] wrPtr;
  logic [klxLoadPkg::creditPtrWidth-1:0] rdPtr;
  logic [klxLoadPkg::creditPtrWidth:0] fifoCount;
  logic [klxLoadPkg::charWidth-1:0] headChar;
  logic popEn;
  logic startOfLine;
  logic pendingEnd;
  logic [klxLoadPkg::charWidth-1:0] lineType;
  logic [klxLoadPkg::fieldWidth-1:0] fieldAcc;

  //////////////////////////////////////////////////////////////////////
  // Credit FIFO
  //////////////////////////////////////////////////////////////////////

  assign headChar = fifoMem[rdPtr];
  // No pop while a line replays or the line-end token is still owed
  assign popEn = (fifoCount != '0) && !hold && !pendingEnd;
  // Every pop hands one credit back to the source
  assign creditReturn = popEn;

  always_ff @(posedge clk) begin
    if (charValid) begin
      fifoMem[wrPtr] <= charIn;
    end
  end

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fifoCount <= '0;
    end else begin
      if (charValid) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (popEn) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({charValid, popEn})
        2'b10: fifoCount <= fifoCount + 1'b1;
        2'b01: fifoCount <= fifoCount - 1'b1;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tokenizer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      token <= '0;
      startOfLine <= 1'b1;
      pendingEnd <= 1'b0;
      lineType <= '0;
      fieldAcc <= '0;
    end else begin
      // Tokens last one cycle
      token.valid <= 1'b0;
      if (pendingEnd) begin
        // Trails the last field by one cycle
        token <= '{valid: 1'b1, kind: klxLoadPkg::tokLineEnd, typeChar: lineType, value: '0};
        pendingEnd <= 1'b0;
      end else if (popEn) begin
        if (startOfLine) begin
          token <= '{valid: 1'b1, kind: klxLoadPkg::tokType, typeChar: headChar, value: '0};
          lineType <= headChar;
          startOfLine <= 1'b0;
          fieldAcc <= '0;
        end else if (headChar == klxLoadPkg::charComma ||
                     headChar == klxLoadPkg::charNewline) begin
          // Empty field between separators gives zero
          token <= '{valid: 1'b1, kind: klxLoadPkg::tokField, typeChar: lineType,
                     value: fieldAcc};
          fieldAcc <= '0;
          if (headChar == klxLoadPkg::charNewline) begin
            pendingEnd <= 1'b1;
            startOfLine <= 1'b1;
          end
        end else if (headChar != klxLoadPkg::charSpace) begin
          // Six payload bits per character, octal 100 dropped
          // High bits fall off past 16
          fieldAcc <= {fieldAcc[klxLoadPkg::fieldWidth-7:0],
                       headChar[klxLoadPkg::charWidth-2:0]};
        end
      end
    end
  end

endmodule

// ==== hdl/klxLoadPkg.sv ====
// Holds every width and type of the loader. CRAM words are numbered with bit 0 as the MSB
package klxLoadPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////////////////////////

  // One load-file word once the ASCIIizing is undone
  localparam int fieldWidth = 16;
  localparam int charWidth = 7;
  // FIFO entries, which is also the source's credit count after reset
  localparam int creditDepth = 4;
  localparam int creditPtrWidth = $clog2(creditDepth);

  localparam int cramAddrWidth = 11;
  localparam int cramWordWidth = 86;
  localparam int dramAddrWidth = 9;
  // J0 is kept in the entry but always reads zero
  localparam int jFieldWidth = 11;

  localparam int cramWordsPerLoc = 6;
  localparam int dramWordsPerPair = 3;
  // Five CRAM locations or ten DRAM pairs
  localparam int maxDataWords = 30;
  localparam int bufIndexWidth = $clog2(maxDataWords);
  localparam int wordCountWidth = 5;
  // Counts WC, ADR, data and CKSUM, and saturates on runaway lines
  localparam int fieldCountWidth = 6;

  // Sized forms for the per-beat arithmetic
  localparam logic [wordCountWidth-1:0] cramStep = wordCountWidth'(cramWordsPerLoc);
  localparam logic [wordCountWidth-1:0] dramStep = wordCountWidth'(dramWordsPerPair);
  localparam logic [fieldWidth-1:0] maxWordCount = fieldWidth'(maxDataWords);

  // Separators and record types
  localparam logic [charWidth-1:0] charComma = 7'h2c;
  localparam logic [charWidth-1:0] charNewline = 7'h0a;
  localparam logic [charWidth-1:0] charSpace = 7'h20;
  localparam logic [charWidth-1:0] charTypeC = 7'h43;
  localparam logic [charWidth-1:0] charTypeD = 7'h44;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {tokType, tokField, tokLineEnd} tokenKindT;

  // Decode to execute, valid for one cycle
  typedef struct packed {
    logic valid;
    tokenKindT kind;
    logic [charWidth-1:0] typeChar;
    logic [fieldWidth-1:0] value;
  } fieldTokenT;

  // Even or odd D-record word, A at bits 13..11 as in the WDRAM layout
  typedef struct packed {
    logic [1:0] spareHigh;
    logic [2:0] aField;
    logic [2:0] bField;
    logic [1:0] spareMid;
    logic parity;
    logic spareLow;
    // J7 in bit 3, J8..J10 below it
    logic [3:0] jLow;
  } dramDataWordT;

  // A stored data word is read raw for CRAM and field-wise for DRAM
  typedef union packed {
    logic [fieldWidth-1:0] raw;
    dramDataWordT dram;
  } loadWordT;

  // Replay request, a zero count means status only
  typedef struct packed {
    logic valid;
    logic isDram;
    logic [cramAddrWidth-1:0] baseAddr;
    logic [wordCountWidth-1:0] wordCount;
  } lineJobT;

  typedef struct packed {
    logic [2:0] aField;
    logic [2:0] bField;
    logic parity;
    logic [0:jFieldWidth-1] jField;
  } dramEntryT;

  typedef struct packed {
    logic valid;
    logic [cramAddrWidth-1:0] addr;
    logic [0:cramWordWidth-1] word;
  } cramWriteT;

  typedef struct packed {
    logic valid;
    logic [dramAddrWidth-1:0] addr;
    dramEntryT even;
    dramEntryT odd;
  } dramWriteT;

  typedef struct packed {
    logic done;
    logic ok;
  } lineStatusT;

endpackage
